// File: Bender.yml
package:
  name: dds_tone

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/dds_pkg.sv
      - src/phase_stepper.sv
      - src/table_arbiter.sv
      - src/wave_rom.sv
      - src/voice_mixer.sv
      - src/dds_top.sv

  - target: test
    include_dirs:
      - src
    files:
      - sim/tb_dds.sv

// File: sim/tb_dds.sv
`timescale 1ns/1ps
`include "dds_cfg.svh"

module tb_dds;

    import dds_pkg::*;

    localparam int  NUM_ROWS    = 8;
    localparam int  TICK_GAP    = 8;      // Edges from one tick edge to the next
    localparam int  MIX_LATENCY = 6;      // Tick edge to the edge that raises mix_valid
    localparam int  WAIT_LIMIT  = 20;
    localparam int  FW          = `DDS_FREQ_W;
    localparam time DRIVE_DLY   = 10ns;

    logic                             clk;
    logic                             rst_n;
    logic                             sample_tick;
    logic [`DDS_NUM_VOICES*FW-1:0]    freq_words;
    logic [`DDS_DIV_W-1:0]            divisor;
    mix_t                             mix_out;
    logic                             mix_valid;

    // Stimulus table with one row per test
    string                  row_name  [NUM_ROWS];
    logic [FW-1:0]          row_freq  [NUM_ROWS][`DDS_NUM_VOICES];
    logic [`DDS_DIV_W-1:0]  row_div   [NUM_ROWS];
    int                     row_ticks [NUM_ROWS];
    bit                     row_rand  [NUM_ROWS];  // Frequency words drawn from the LCG

    // Reference model state
    longint model_acc  [`DDS_NUM_VOICES];
    int     model_addr [`DDS_NUM_VOICES];
    int     wave       [`DDS_TABLE_DEPTH];

    logic [31:0] rng_state;
    int          check_count;
    int          error_count;
    int          timeout_count;

    dds_top UUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .sample_tick (sample_tick),
        .freq_words  (freq_words),
        .divisor     (divisor),
        .mix_out     (mix_out),
        .mix_valid   (mix_valid)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic build_wave();
        for (int i = 0; i < `DDS_TABLE_DEPTH; i++) begin
            wave[i] = ((i < 256) ? i : 511 - i) * 256 - 32768;  // Triangle peaking at 255/256
        end
    endtask

    task automatic model_reset();
        for (int v = 0; v < `DDS_NUM_VOICES; v++) begin
            model_acc[v]  = 0;
            model_addr[v] = 256;
        end
    endtask

    // Capped floor quotient of the sum by the divisor with the remainder kept
    task automatic model_tick(input int v, input longint freq, input longint div);
        longint total;
        longint quot;
        if (div != 0) begin
            total = model_acc[v] + freq;
            quot  = total / div;
            if (quot > `DDS_MAX_STEP) begin
                quot = `DDS_MAX_STEP;
            end
            model_acc[v]  = total - quot * div;
            model_addr[v] = (model_addr[v] + int'(quot)) % `DDS_TABLE_DEPTH;
        end
    endtask

    function automatic mix_t model_mix();
        int total;
        total = 0;
        for (int v = 0; v < `DDS_NUM_VOICES; v++) begin
            total += wave[model_addr[v]];
        end
        return total[`DDS_MIX_W-1:0];     // 18-bit wrap
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus table
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic set_row(input int r, input string name, input logic [FW-1:0] f0,
                           input logic [FW-1:0] f1, input logic [FW-1:0] f2,
                           input logic [FW-1:0] f3, input logic [`DDS_DIV_W-1:0] div,
                           input int ticks, input bit rnd);
        row_name[r]    = name;
        row_freq[r][0] = f0;
        row_freq[r][1] = f1;
        row_freq[r][2] = f2;
        row_freq[r][3] = f3;
        row_div[r]     = div;
        row_ticks[r]   = ticks;
        row_rand[r]    = rnd;
    endtask

    task automatic load_table();
        set_row(0, "zero_freq",     0,     0,     0,     0,    1000,  2,  0);
        set_row(1, "quotient_step", 1500,  2300,  500,   999,  1000,  10, 0);
        set_row(2, "cap_at_16",     20000, 20000, 20000, 20000, 1000, 6,  0);
        set_row(3, "wrap_long",     15999, 15000, 12345, 8000, 1000,  40, 0);
        set_row(4, "zero_div",      5000,  7000,  9000,  11000, 0,    4,  0);
        set_row(5, "independent",   3 * 4321 + 7, 7 * 4321 + 1, 11 * 4321 + 500, 4321,
                4321, 12, 0);
        set_row(6, "random_a",      0,     0,     0,     0,    777,    16, 1);
        set_row(7, "random_b",      0,     0,     0,     0,    100000, 16, 1);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic check_idle(input int cycles);
        for (int c = 0; c < cycles; c++) begin
            @(posedge clk);
            #DRIVE_DLY;
            check_count++;
            if (mix_valid !== 1'b0) begin
                error_count++;
                $display("mix_valid went high after reset with no tick");
            end
            if (mix_out !== '0) begin
                error_count++;
                $display("[ERROR] reset_state mix_out: expected 0, actual %0d", mix_out);
            end
        end
    endtask

    // One tick followed by the wait for its frame and the quiet cycles up to the next tick
    task automatic play_tick(input string name, input int k, input mix_t expected);
        int   waited;
        bit   seen;
        sample_tick = 1'b1;
        @(posedge clk);                       // Tick edge
        #DRIVE_DLY;
        sample_tick = 1'b0;
        waited = 0;
        seen   = 1'b0;
        while (!seen && waited < WAIT_LIMIT) begin
            @(posedge clk);
            #DRIVE_DLY;
            waited++;
            seen = mix_valid;
        end
        if (!seen) begin
            timeout_count++;
            $display("%s tick %0d: mix_valid never came within %0d cycles", name, k,
                     WAIT_LIMIT);
        end else begin
            check_count++;
            if (waited != MIX_LATENCY) begin
                error_count++;
                $display("[ERROR] %s tick %0d latency: expected %0d, actual %0d",
                         name, k, MIX_LATENCY, waited);
            end
            if (mix_out !== expected) begin
                error_count++;
                $display("[ERROR] %s tick %0d mix_out: expected %0d, actual %0d",
                         name, k, expected, mix_out);
            end
            while (waited < TICK_GAP - 1) begin
                @(posedge clk);
                #DRIVE_DLY;
                waited++;
                if (mix_valid !== 1'b0) begin
                    error_count++;
                    $display("%s tick %0d: mix_valid high again %0d cycles after the tick",
                             name, k, waited);
                end
                if (mix_out !== expected) begin
                    error_count++;
                    $display("[ERROR] %s tick %0d hold: expected %0d, actual %0d",
                             name, k, expected, mix_out);
                end
            end
        end
    endtask

    task automatic run_row(input int r);
        logic [FW-1:0] freq [`DDS_NUM_VOICES];
        mix_t          expected;
        for (int v = 0; v < `DDS_NUM_VOICES; v++) begin
            freq[v] = row_freq[r][v];
            if (row_rand[r]) begin
                rng_state = lcg_next(rng_state);
                freq[v]   = rng_state % (`DDS_MAX_STEP * row_div[r]);  // Below the cap
            end
            freq_words[v*FW +: FW] = freq[v];
        end
        divisor = row_div[r];
        for (int k = 0; k < row_ticks[r]; k++) begin
            for (int v = 0; v < `DDS_NUM_VOICES; v++) begin
                model_tick(v, freq[v], row_div[r]);
            end
            expected = model_mix();
            play_tick(row_name[r], k, expected);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Main sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        rst_n         = 1'b0;
        sample_tick   = 1'b0;
        freq_words    = '0;
        divisor       = '0;
        rng_state     = 32'hf30c_b285;
        check_count   = 0;
        error_count   = 0;
        timeout_count = 0;
        build_wave();
        model_reset();
        load_table();

        repeat (2) @(posedge clk);
        #DRIVE_DLY;
        rst_n = 1'b1;
        check_idle(5);

        for (int r = 0; r < NUM_ROWS; r++) begin
            run_row(r);
        end

        $display("Checks: %0d, value errors: %0d, timeouts: %0d",
                 check_count, error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: src/dds_cfg.svh
`ifndef DDS_CFG_SVH
`define DDS_CFG_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Voice and table geometry
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define DDS_NUM_VOICES   4
`define DDS_ADDR_W       9
`define DDS_TABLE_DEPTH  512
`define DDS_SAMPLE_W     16
`define DDS_MIX_W        18      // Four 16-bit samples need two guard bits

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Phase stepping
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define DDS_FREQ_W       32
`define DDS_DIV_W        17
`define DDS_ACC_W        34      // Headroom for remainders above the cap
`define DDS_MAX_STEP     16
`define DDS_RESET_ADDR   256     // Middle of the table, top of the triangle

`endif

// File: src/dds_pkg.sv
`include "dds_cfg.svh"

package dds_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Datapath types
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Waveform table address
    typedef logic [`DDS_ADDR_W-1:0] addr_t;

    // One table sample, two's complement
    typedef logic signed [`DDS_SAMPLE_W-1:0] sample_t;

    // Sum of all voices
    typedef logic signed [`DDS_MIX_W-1:0] mix_t;

    // Phase remainder carried between ticks
    typedef logic [`DDS_ACC_W-1:0] acc_t;

    // Index of one voice
    typedef logic [$clog2(`DDS_NUM_VOICES)-1:0] voice_sel_t;

endpackage

// File: src/dds_top.sv
`timescale 1ns/1ps
`include "dds_cfg.svh"

module dds_top (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic                                    sample_tick,
    input  logic [`DDS_NUM_VOICES*`DDS_FREQ_W-1:0]  freq_words,
    input  logic [`DDS_DIV_W-1:0]                   divisor,
    output dds_pkg::mix_t                           mix_out,
    output logic                                    mix_valid
);

    import dds_pkg::*;

    logic [`DDS_NUM_VOICES-1:0]  req;
    logic [`DDS_NUM_VOICES-1:0]  grant;
    addr_t                       voice_addr [`DDS_NUM_VOICES];
    logic                        rd_en;
    voice_sel_t                  rd_voice;
    addr_t                       rd_addr;
    sample_t                     rd_data;
    logic                        data_valid;
    voice_sel_t                  data_voice;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Voices
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    for (genvar v = 0; v < `DDS_NUM_VOICES; v++) begin : g_voice
        phase_stepper u_stepper (
            .clk       (clk),
            .rst_n     (rst_n),
            .step      (sample_tick),
            .freq_word (freq_words[v*`DDS_FREQ_W +: `DDS_FREQ_W]),
            .divisor   (divisor),
            .grant     (grant[v]),
            .addr      (voice_addr[v]),
            .req       (req[v])
        );
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Shared table access
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    table_arbiter u_arbiter (
        .clk      (clk),
        .rst_n    (rst_n),
        .req      (req),
        .grant    (grant),
        .rd_en    (rd_en),
        .rd_voice (rd_voice)
    );

    assign rd_addr = voice_addr[rd_voice];   // Addresses are stable until next tick

    wave_rom u_rom (
        .clk        (clk),
        .rd_en      (rd_en),
        .rd_addr    (rd_addr),
        .rd_voice   (rd_voice),
        .rd_data    (rd_data),
        .data_valid (data_valid),
        .data_voice (data_voice)
    );

    voice_mixer u_mixer (
        .clk        (clk),
        .rst_n      (rst_n),
        .data_valid (data_valid),
        .data_voice (data_voice),
        .rd_data    (rd_data),
        .mix_out    (mix_out),
        .mix_valid  (mix_valid)
    );

endmodule

// File: src/phase_stepper.sv
`timescale 1ns/1ps
`include "dds_cfg.svh"

module phase_stepper (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    step,
    input  logic [`DDS_FREQ_W-1:0]  freq_word,
    input  logic [`DDS_DIV_W-1:0]   divisor,
    input  logic                    grant,
    output dds_pkg::addr_t          addr,
    output logic                    req
);

    import dds_pkg::*;

    localparam int QW = $clog2(`DDS_MAX_STEP + 1);

    acc_t          acc;
    acc_t          sum;
    acc_t          remainder;
    logic [QW-1:0] quot;
    logic          div_ok;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Quotient ladder
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign div_ok = (divisor != '0);

    // Largest multiple k of divisor not above sum, k in 1..MAX_STEP
    always_comb begin
        sum  = acc + acc_t'(freq_word);
        quot = '0;
        for (int k = 1; k <= `DDS_MAX_STEP; k++) begin
            if (sum >= acc_t'(divisor) * acc_t'(k)) begin
                quot = k[QW-1:0];           // Multiples rise, last hit wins
            end
        end
        remainder = sum - acc_t'(divisor) * acc_t'(quot);  // Excess over cap stays here
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Phase state and table request
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            addr <= addr_t'(`DDS_RESET_ADDR);
            acc  <= '0;
        end else if (step && div_ok) begin
            addr <= addr + addr_t'(quot);     // Wraps modulo table depth
            acc  <= remainder;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            req <= 1'b0;
        end else if (step) begin
            req <= 1'b1;                      // New address wants a read
        end else if (grant) begin
            req <= 1'b0;
        end
    end

endmodule

// File: src/table_arbiter.sv
`timescale 1ns/1ps
`include "dds_cfg.svh"

module table_arbiter (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [`DDS_NUM_VOICES-1:0]  req,
    output logic [`DDS_NUM_VOICES-1:0]  grant,
    output logic                        rd_en,
    output dds_pkg::voice_sel_t         rd_voice
);

    import dds_pkg::*;

    voice_sel_t                  ptr;         // First voice to look at
    voice_sel_t                  cand;
    voice_sel_t                  win_voice;
    logic                        win_found;
    logic [`DDS_NUM_VOICES-1:0]  pending;
    logic [`DDS_NUM_VOICES-1:0]  grant_next;

    // A voice granted this cycle still shows req until the next edge
    assign pending = req & ~grant;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Round-robin pick
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        win_found = 1'b0;
        win_voice = '0;
        cand      = '0;
        for (int i = 0; i < `DDS_NUM_VOICES; i++) begin
            cand = voice_sel_t'(int'(ptr) + i);   // Wraps around the voice ring
            if (!win_found && pending[cand]) begin
                win_found = 1'b1;
                win_voice = cand;
            end
        end
        grant_next            = '0;
        grant_next[win_voice] = win_found;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ptr      <= '0;
            grant    <= '0;
            rd_en    <= 1'b0;
            rd_voice <= '0;
        end else begin
            grant <= grant_next;
            rd_en <= win_found;
            if (win_found) begin
                ptr      <= win_voice + 1'b1;     // Next search starts past the winner
                rd_voice <= win_voice;
            end
        end
    end

endmodule

// File: src/voice_mixer.sv
`timescale 1ns/1ps
`include "dds_cfg.svh"

module voice_mixer (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 data_valid,
    input  dds_pkg::voice_sel_t  data_voice,
    input  dds_pkg::sample_t     rd_data,
    output dds_pkg::mix_t        mix_out,
    output logic                 mix_valid
);

    import dds_pkg::*;

    mix_t                        sum_acc;
    mix_t                        sample_ext;
    logic [`DDS_NUM_VOICES-1:0]  seen;          // Voices returned so far this frame
    logic [`DDS_NUM_VOICES-1:0]  seen_next;
    logic                        frame_done;

    assign sample_ext = mix_t'(rd_data);       // Sign extends
    // Frame ends with the return that completes the set of voices
    always_comb begin
        seen_next             = seen;
        seen_next[data_voice] = 1'b1;
    end
    assign frame_done = data_valid && (&seen_next);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Running sum and output pulse
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sum_acc   <= '0;
            seen      <= '0;
            mix_out   <= '0;
            mix_valid <= 1'b0;
        end else begin
            mix_valid <= 1'b0;
            if (frame_done) begin
                mix_out   <= sum_acc + sample_ext;   // Wraps at mix width
                mix_valid <= 1'b1;
                sum_acc   <= '0;
                seen      <= '0;
            end else if (data_valid) begin
                sum_acc <= sum_acc + sample_ext;
                seen    <= seen_next;
            end
        end
    end

endmodule

// File: src/wave_rom.sv
`timescale 1ns/1ps
`include "dds_cfg.svh"

module wave_rom (
    input  logic                    clk,
    input  logic                    rd_en,
    input  logic [`DDS_ADDR_W-1:0]  rd_addr,
    input  dds_pkg::voice_sel_t     rd_voice,
    output dds_pkg::sample_t        rd_data,
    output logic                    data_valid,
    output dds_pkg::voice_sel_t     data_voice
);

    import dds_pkg::*;

    localparam int HALF   = `DDS_TABLE_DEPTH / 2;
    localparam int SCALE  = (2 ** `DDS_SAMPLE_W) / HALF;  // One rising half spans full range
    localparam int OFFSET = 2 ** (`DDS_SAMPLE_W - 1);

    sample_t mem [`DDS_TABLE_DEPTH];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Triangle contents
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        for (int i = 0; i < `DDS_TABLE_DEPTH; i++) begin
            if (i < HALF) begin
                mem[i] = sample_t'(i * SCALE - OFFSET);                        // Rising
            end else begin
                mem[i] = sample_t'((`DDS_TABLE_DEPTH - 1 - i) * SCALE - OFFSET); // Falling
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Registered read
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
        data_voice <= rd_voice;       // Tag travels with the sample
        data_valid <= rd_en;
    end

endmodule

// File: tb.f
+incdir+src
src/dds_pkg.sv
src/phase_stepper.sv
src/table_arbiter.sv
src/wave_rom.sv
src/voice_mixer.sv
src/dds_top.sv
sim/tb_dds.sv
